//--- mipsPkg.sv
package mipsPkg;

  // ====================
  // opcode field
  // ====================

  // r-type shares one opcode, funct picks the op
  localparam logic [5:0] opRType = 6'b000000;
  localparam logic [5:0] opLw    = 6'b100011;
  localparam logic [5:0] opSw    = 6'b101011;
  localparam logic [5:0] opBeq   = 6'b000100;
  localparam logic [5:0] opJ     = 6'b000010;
  localparam logic [5:0] opJal   = 6'b000011;

  // ====================
  // funct field
  // ====================

  localparam logic [5:0] functAdd = 6'b100000;
  localparam logic [5:0] functSub = 6'b100010;
  localparam logic [5:0] functAnd = 6'b100100;
  localparam logic [5:0] functOr  = 6'b100101;
  localparam logic [5:0] functSlt = 6'b101010;
  localparam logic [5:0] functJr  = 6'b001000;

  // ====================
  // alu encodings
  // ====================

  // classic textbook alu control values
  typedef enum logic [3:0] {
    aluAnd = 4'b0000,
    aluOr  = 4'b0001,
    aluAdd = 4'b0010,
    aluSub = 4'b0110,
    aluSlt = 4'b0111
  } aluOpT;

  // what the main decoder tells the alu decoder
  typedef enum logic [1:0] {
    clsMem   = 2'b00,
    clsCmp   = 2'b01,
    clsFunct = 2'b10
  } aluClassT;

  // register file address width
  localparam int regAddrW = 5;

endpackage

//--- alu.sv
`timescale 1ns/10ps

module alu import mipsPkg::*; (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  aluOpT       aluOp,
  output logic [31:0] result,
  output logic        zero
);

  // signed compare for slt
  logic lessThan;

  assign lessThan = ($signed(a) < $signed(b));

  always_comb begin
    case (aluOp)
      aluAdd:  result = a + b;
      aluSub:  result = a - b;
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluSlt:  result = {31'd0, lessThan};
      default: result = a + b;
    endcase
  end

  // flag for every op, only beq looks at it
  assign zero = (result == 32'd0);

endmodule

//--- aluControl.sv
`timescale 1ns/10ps

module aluControl import mipsPkg::*; (
  input  aluClassT   aluClass,
  input  logic [5:0] funct,
  output aluOpT      aluOp
);

  // r-type funct to alu op
  aluOpT functOp;

  always_comb begin
    case (funct)
      functAdd: functOp = aluAdd;
      functSub: functOp = aluSub;
      functAnd: functOp = aluAnd;
      functOr:  functOp = aluOr;
      functSlt: functOp = aluSlt;
      // jr and anything undecoded
      default:  functOp = aluAdd;
    endcase
  end

  always_comb begin
    case (aluClass)
      // lw / sw base plus offset
      clsMem:   aluOp = aluAdd;
      // beq equality via subtract
      clsCmp:   aluOp = aluSub;
      clsFunct: aluOp = functOp;
      default:  aluOp = aluAdd;
    endcase
  end

endmodule

//--- controlUnit.sv
`timescale 1ns/10ps

module controlUnit import mipsPkg::*; (
  input  logic [5:0] opcode,
  input  logic [5:0] funct,
  output logic       regDst,
  output logic       aluSrc,
  output logic       memToReg,
  output logic       regWrite,
  output logic       memRead,
  output logic       memWrite,
  output logic       jump,
  output logic       link,
  output logic       jumpReg,
  output logic       branch,
  output aluClassT   aluClass
);

  // r-type ops that write rd
  logic rArith;

  assign rArith = funct inside {functAdd, functSub, functAnd, functOr, functSlt};

  always_comb begin
    // everything idle unless the opcode says otherwise
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    jump     = 1'b0;
    link     = 1'b0;
    jumpReg  = 1'b0;
    branch   = 1'b0;
    aluClass = clsMem;
    case (opcode)
      opRType: begin
        // jr writes nothing
        // unknown funct such as the sll nop stays inert
        regDst   = 1'b1;
        regWrite = rArith;
        jumpReg  = (funct == functJr);
        aluClass = clsFunct;
      end
      opLw: begin
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
        memRead  = 1'b1;
      end
      opSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      opBeq: begin
        // compare by subtract and let the zero flag decide
        branch   = 1'b1;
        aluClass = clsCmp;
      end
      opJ: begin
        jump = 1'b1;
      end
      opJal: begin
        // link path overrides write address and data
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: begin
        regWrite = 1'b0;
      end
    endcase
  end

endmodule

//--- registerFile.sv
`timescale 1ns/10ps

module registerFile import mipsPkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                regWrite,
  input  logic [regAddrW-1:0] readAddr1,
  input  logic [regAddrW-1:0] readAddr2,
  input  logic [regAddrW-1:0] writeAddr,
  input  logic [31:0]         writeData,
  output logic [31:0]         readData1,
  output logic [31:0]         readData2
);

  localparam int numRegs = 2 ** regAddrW;

  // ====================
  // storage
  // ====================

  logic [31:0] regs [numRegs];

  // write at end of cycle, $zero never takes a write
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (regWrite && (writeAddr != '0)) begin
      regs[writeAddr] <= writeData;
    end
  end

  // ====================
  // read ports
  // ====================

  // combinational, same cycle as decode
  assign readData1 = regs[readAddr1];
  assign readData2 = regs[readAddr2];

  // $zero holds across every write the core issues
  assert property (@(posedge clk) disable iff (!rst)
    (readAddr1 == '0) |-> (readData1 == 32'd0))
    else $error("registerFile: port 1 read of $zero is not zero");

  assert property (@(posedge clk) disable iff (!rst)
    (readAddr2 == '0) |-> (readData2 == 32'd0))
    else $error("registerFile: port 2 read of $zero is not zero");

endmodule

//--- programCounter.sv
`timescale 1ns/10ps

module programCounter #(
  parameter logic [31:0] resetPc = 32'h0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] branchOffset,
  input  logic [25:0] jumpTarget,
  input  logic [31:0] jumpAddr,
  input  logic        jump,
  input  logic        jumpReg,
  input  logic        branch,
  input  logic        zero,
  output logic [31:0] pc,
  output logic [31:0] pcPlus4
);

  logic [31:0] pcNext;
  logic [31:0] branchDest;

  assign pcPlus4    = pc + 32'd4;
  // word offset relative to the next instruction
  assign branchDest = pcPlus4 + {branchOffset[29:0], 2'b00};

  // next pc, highest priority first
  always_comb begin
    if (jumpReg) begin
      pcNext = jumpAddr;
    end else if (jump) begin
      // stays inside the current 256 MB region
      pcNext = {pcPlus4[31:28], jumpTarget, 2'b00};
    end else if (branch && zero) begin
      pcNext = branchDest;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= resetPc;
    end else begin
      pc <= pcNext;
    end
  end

  // fetch address must stay on word boundaries
  assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00)
    else $error("programCounter: unaligned pc %h", pc);

endmodule

//--- singleCycleMips.sv
`timescale 1ns/10ps

module singleCycleMips import mipsPkg::*; #(
  parameter logic [31:0] resetPc   = 32'h0,
  parameter int          dataAddrW = 7
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [31:0]          IR,
  output logic [31:0]          IR_addr,
  output logic [31:0]          RF_writedata,
  input  logic [31:0]          ReadDataMem,
  output logic                 CEN,
  output logic                 WEN,
  output logic [dataAddrW-1:0] A,
  output logic [31:0]          ReadData2
);

  // ====================
  // instruction fields
  // ====================

  logic [5:0]          opcode;
  logic [5:0]          funct;
  logic [regAddrW-1:0] rs;
  logic [regAddrW-1:0] rt;
  logic [regAddrW-1:0] rd;
  logic [15:0]         imm;
  logic [25:0]         target;
  logic [31:0]         signImm;

  assign opcode  = IR[31:26];
  assign rs      = IR[25:21];
  assign rt      = IR[20:16];
  assign rd      = IR[15:11];
  assign imm     = IR[15:0];
  assign funct   = IR[5:0];
  assign target  = IR[25:0];
  assign signImm = {{16{imm[15]}}, imm};

  // control levels
  logic     regDst;
  logic     aluSrc;
  logic     memToReg;
  logic     regWrite;
  logic     memRead;
  logic     memWrite;
  logic     jump;
  logic     link;
  logic     jumpReg;
  logic     branch;
  aluClassT aluClass;
  aluOpT    aluOp;

  // datapath
  logic [31:0]         pc;
  logic [31:0]         pcPlus4;
  logic [31:0]         rsData;
  logic [31:0]         rtData;
  logic [31:0]         aluB;
  logic [31:0]         aluResult;
  logic                zero;
  logic [regAddrW-1:0] writeAddr;
  logic [31:0]         writeData;

  // ====================
  // datapath muxes
  // ====================

  // immediate for lw / sw, rt otherwise
  assign aluB = aluSrc ? signImm : rtData;

  // jal links into $ra
  assign writeAddr = link ? regAddrW'(31) : (regDst ? rd : rt);

  // link value is pc+4, no delay slot
  assign writeData = link ? pcPlus4 : (memToReg ? ReadDataMem : aluResult);

  // ====================
  // submodules
  // ====================

  programCounter #(
    .resetPc (resetPc)
  ) programCounterInst (
    .clk          (clk),
    .rst          (rst),
    .branchOffset (signImm),
    .jumpTarget   (target),
    .jumpAddr     (rsData),
    .jump         (jump),
    .jumpReg      (jumpReg),
    .branch       (branch),
    .zero         (zero),
    .pc           (pc),
    .pcPlus4      (pcPlus4)
  );

  controlUnit controlUnitInst (
    .opcode   (opcode),
    .funct    (funct),
    .regDst   (regDst),
    .aluSrc   (aluSrc),
    .memToReg (memToReg),
    .regWrite (regWrite),
    .memRead  (memRead),
    .memWrite (memWrite),
    .jump     (jump),
    .link     (link),
    .jumpReg  (jumpReg),
    .branch   (branch),
    .aluClass (aluClass)
  );

  aluControl aluControlInst (
    .aluClass (aluClass),
    .funct    (funct),
    .aluOp    (aluOp)
  );

  alu aluInst (
    .a      (rsData),
    .b      (aluB),
    .aluOp  (aluOp),
    .result (aluResult),
    .zero   (zero)
  );

  registerFile registerFileInst (
    .clk       (clk),
    .rst       (rst),
    .regWrite  (regWrite),
    .readAddr1 (rs),
    .readAddr2 (rt),
    .writeAddr (writeAddr),
    .writeData (writeData),
    .readData1 (rsData),
    .readData2 (rtData)
  );

  // ====================
  // external ports
  // ====================

  assign IR_addr      = pc;
  assign RF_writedata = writeData;

  // data sram strobes are active low
  assign CEN = ~(memRead | memWrite);
  assign WEN = ~memWrite;

  // word address, byte offset dropped
  assign A         = aluResult[dataAddrW+1:2];
  assign ReadData2 = rtData;

endmodule

//--- tbClock.sv
`timescale 1ns/10ps

module tbClock #(
  parameter int periodNs = 40
) (
  output logic clk
);

  // free running, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #(periodNs / 2) clk = ~clk;
    end
  end

endmodule

//--- tbMips.sv
`timescale 1ns/10ps

module tbMips import mipsPkg::*; ();

  localparam int          clkPeriod    = 40;
  localparam int          resetCycles  = 16;
  localparam int          numInstr     = 2000;
  localparam int          marginCycles = 100;
  localparam logic [31:0] resetPc      = 32'h0;
  localparam int          dataAddrW    = 7;

  logic                 clk;
  logic                 rst;
  logic [31:0]          IR;
  logic [31:0]          IR_addr;
  logic [31:0]          RF_writedata;
  logic [31:0]          ReadDataMem;
  logic                 CEN;
  logic                 WEN;
  logic [dataAddrW-1:0] A;
  logic [31:0]          ReadData2;

  // memories on the dut side
  logic [31:0] instrMem [256];
  logic [31:0] dataMem [256];

  // reference model state
  logic [31:0] modelRegs [32];
  logic [31:0] modelMem [256];
  logic [31:0] modelPc;

  integer seed;

  tbClock #(.periodNs(clkPeriod)) tbClockInst (.clk(clk));

  singleCycleMips #(
    .resetPc   (resetPc),
    .dataAddrW (dataAddrW)
  ) singleCycleMips_inst (
    .clk          (clk),
    .rst          (rst),
    .IR           (IR),
    .IR_addr      (IR_addr),
    .RF_writedata (RF_writedata),
    .ReadDataMem  (ReadDataMem),
    .CEN          (CEN),
    .WEN          (WEN),
    .A            (A),
    .ReadData2    (ReadData2)
  );

  // ====================
  // memory models
  // ====================

  // sll zero while in reset
  assign IR          = rst ? instrMem[IR_addr[9:2]] : 32'h0;
  assign ReadDataMem = dataMem[8'(A)];

  always @(posedge clk) begin
    if (rst && !WEN) begin
      dataMem[8'(A)] = ReadData2;
    end
  end

  // ====================
  // helpers
  // ====================

  function automatic int randomBelow(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
    return {opRType, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic compareValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch at %0t", $time);
    end
  endtask

  // random legal program, random data
  task automatic generateProgram();
    logic [5:0] arithFunct [5];
    logic [4:0] rs;
    logic [4:0] rt;
    int         kind;
    arithFunct = '{functAdd, functSub, functAnd, functOr, functSlt};
    for (int i = 0; i < 256; i++) begin
      kind = randomBelow(20);
      rs   = 5'(randomBelow(32));
      // r31 only ever written by jal, so jr stays aligned
      rt   = 5'(randomBelow(31));
      if (kind < 10) begin
        instrMem[i] = encodeR(rs, 5'(randomBelow(32)), rt, arithFunct[randomBelow(5)]);
      end else if (kind < 13) begin
        instrMem[i] = encodeI(opLw, rs, rt, 16'($random(seed)));
      end else if (kind < 15) begin
        instrMem[i] = encodeI(opSw, rs, 5'(randomBelow(32)), 16'($random(seed)));
      end else if (kind < 17) begin
        // half of them compare a register with itself
        if (randomBelow(2) == 0) begin
          rt = rs;
        end
        // forward only, no branch self-loops
        instrMem[i] = encodeI(opBeq, rs, rt, 16'(randomBelow(8)));
      end else if (kind == 17) begin
        instrMem[i] = {opJ, 26'(randomBelow(256))};
      end else if (kind == 18) begin
        instrMem[i] = {opJal, 26'(randomBelow(256))};
      end else begin
        instrMem[i] = encodeR(5'd31, 5'd0, 5'd0, functJr);
      end
      dataMem[i]  = $random(seed);
      modelMem[i] = dataMem[i];
    end
    for (int r = 0; r < 32; r++) begin
      modelRegs[r] = 32'd0;
    end
    modelPc = resetPc;
  endtask

  // ====================
  // reference model
  // ====================

  // checks the dut against one instruction, then advances the model
  task automatic stepModel();
    logic [31:0]          instr;
    logic [31:0]          rsVal;
    logic [31:0]          rtVal;
    logic [31:0]          signImm;
    logic [31:0]          addr;
    logic [31:0]          result;
    logic [31:0]          pcPlus4;
    logic [31:0]          nextPc;
    logic [dataAddrW-1:0] wordAddr;
    logic [4:0]           dest;
    logic                 writes;
    logic                 isMem;
    instr    = instrMem[modelPc[9:2]];
    rsVal    = modelRegs[instr[25:21]];
    rtVal    = modelRegs[instr[20:16]];
    signImm  = {{16{instr[15]}}, instr[15:0]};
    addr     = rsVal + signImm;
    wordAddr = addr[dataAddrW+1:2];
    pcPlus4  = modelPc + 32'd4;
    nextPc   = pcPlus4;
    result   = 32'd0;
    dest     = instr[15:11];
    writes   = 1'b0;
    isMem    = 1'b0;
    compareValue("pc", modelPc, IR_addr);
    case (instr[31:26])
      opRType: begin
        writes = 1'b1;
        case (instr[5:0])
          functAdd: result = rsVal + rtVal;
          functSub: result = rsVal - rtVal;
          functAnd: result = rsVal & rtVal;
          functOr:  result = rsVal | rtVal;
          functSlt: result = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
          default: begin
            // jr
            writes = 1'b0;
            nextPc = rsVal;
          end
        endcase
      end
      opLw: begin
        isMem  = 1'b1;
        writes = 1'b1;
        dest   = instr[20:16];
        result = modelMem[8'(wordAddr)];
        compareValue("lwAddr", 32'(wordAddr), 32'(A));
        compareValue("lwWen", 32'd1, {31'd0, WEN});
      end
      opSw: begin
        isMem = 1'b1;
        compareValue("swAddr", 32'(wordAddr), 32'(A));
        compareValue("swData", rtVal, ReadData2);
        compareValue("swWen", 32'd0, {31'd0, WEN});
        modelMem[8'(wordAddr)] = rtVal;
      end
      opBeq: begin
        if (rsVal == rtVal) begin
          nextPc = pcPlus4 + {signImm[29:0], 2'b00};
        end
      end
      default: begin
        // j and jal share the region jump
        nextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
        if (instr[31:26] == opJal) begin
          writes = 1'b1;
          dest   = 5'd31;
          result = pcPlus4;
        end
      end
    endcase
    compareValue("cen", {31'd0, !isMem}, {31'd0, CEN});
    if (!isMem) begin
      compareValue("wenIdle", 32'd1, {31'd0, WEN});
    end
    if (writes) begin
      compareValue("rfWriteData", result, RF_writedata);
      if (dest != 5'd0) begin
        modelRegs[dest] = result;
      end
    end
    modelPc = nextPc;
  endtask

  // ====================
  // stimulus and checking
  // ====================

  initial begin
    seed = 32'hb22f_3c2d;
    rst  = 1'b0;
    generateProgram();
    repeat (resetCycles) @(negedge clk);
    // nop in reset keeps the sram idle
    compareValue("cenReset", 32'd1, {31'd0, CEN});
    compareValue("wenReset", 32'd1, {31'd0, WEN});
    rst = 1'b1;
    for (int n = 0; n < numInstr; n++) begin
      // sample mid low phase, well clear of both edges
      #(clkPeriod / 4);
      stepModel();
      @(negedge clk);
    end
    $display("Simulation PASSED");
    $finish;
  end

  // watchdog
  initial begin
    #((resetCycles + numInstr + marginCycles) * clkPeriod);
    $display("run did not complete in %0d cycles", resetCycles + numInstr + marginCycles);
    $display("Simulation FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule

//--- project.f
mipsPkg.sv
alu.sv
aluControl.sv
controlUnit.sv
registerFile.sv
programCounter.sv
singleCycleMips.sv
tbClock.sv
tbMips.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP      = tbMips
FILELIST = project.f
BUILDDIR = obj_dir

SOURCES  = $(shell cat $(FILELIST))
EXE      = $(BUILDDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

run: compile
	./$(EXE)

clean:
	rm -rf $(BUILDDIR)
